// ==== hw/aes256_enc.sv ====
// AES-256 encryption core with iterative round controller and loadable key
`timescale 1ns/1ps

module aes256_enc (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_key_t   key,
    input  logic                key_load,
    input  aes_pkg::aes_block_t in_block,
    input  logic                in_valid,
    output logic                key_ready,
    output logic                busy,
    output aes_pkg::aes_block_t out_block,
    output logic                out_valid
);
    import aes_pkg::*;
    import aes_ctrl_pkg::*;

    localparam aes_round_t LAST_ROUND = aes_round_t'(NUM_ROUNDS);

    enc_state_t enc_state;
    aes_round_t round;
    aes_block_t state_q;
    aes_block_t round_key;
    aes_block_t ss_state_out;
    aes_block_t mix_out;
    logic       accept;
    logic       ks_load;
    logic       ss_start;
    logic       ss_done;
    logic       mix_load;

    // New block only when idle with a valid key
    assign accept = in_valid && key_ready && !busy;

    // Key change blocked while a block is running
    assign ks_load = key_load && !busy && !accept;

    assign ss_start = (enc_state == ENC_SUB_SHIFT);
    assign mix_load = (enc_state == ENC_MIX);

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .resetn    (resetn),
        .key       (key),
        .key_load  (ks_load),
        .rk_addr   (round),
        .round_key (round_key),
        .key_ready (key_ready)
    );

    aes_sub_shift u_sub_shift (
        .clk       (clk),
        .resetn    (resetn),
        .start     (ss_start),
        .state_in  (state_q),
        .state_out (ss_state_out),
        .done      (ss_done)
    );

    aes_mix_columns u_mix_columns (
        .clk     (clk),
        .resetn  (resetn),
        .load    (mix_load),
        .mix_in  (ss_state_out),
        .mix_out (mix_out)
    );

    // Round controller
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            enc_state <= ENC_IDLE;
            round <= '0;
            busy <= 1'b0;
            out_valid <= 1'b0;
            out_block <= '0;
        end
        else
        begin
            out_valid <= 1'b0;
            case (enc_state)
                ENC_IDLE:
                begin
                    round <= '0;
                    if (accept)
                    begin
                        busy <= 1'b1;
                        enc_state <= ENC_ADD_KEY;
                    end
                end
                // Key 14 applied means the block is finished
                ENC_ADD_KEY:
                begin
                    if (round == LAST_ROUND)
                        enc_state <= ENC_DONE;
                    else
                    begin
                        round <= round + 4'd1;
                        enc_state <= ENC_SUB_SHIFT;
                    end
                end
                ENC_SUB_SHIFT:
                    enc_state <= ENC_SUB_WAIT;
                // No MixColumns in the final round
                ENC_SUB_WAIT:
                begin
                    if (ss_done)
                        enc_state <= (round == LAST_ROUND) ? ENC_STORE : ENC_MIX;
                end
                ENC_MIX:
                    enc_state <= ENC_STORE;
                ENC_STORE:
                    enc_state <= ENC_ADD_KEY;
                ENC_DONE:
                begin
                    out_block <= state_q;
                    out_valid <= 1'b1;
                    busy <= 1'b0;
                    enc_state <= ENC_IDLE;
                end
                default:
                    enc_state <= ENC_IDLE;
            endcase
        end
    end

    // State register, fed by input, AddRoundKey or round result
    always_ff @(posedge clk)
    begin
        if (accept)
            state_q <= in_block;
        else if (enc_state == ENC_ADD_KEY)
            state_q <= state_q ^ round_key;
        else if (enc_state == ENC_STORE)
            state_q <= (round == LAST_ROUND) ? ss_state_out : mix_out;
    end

endmodule

// ==== hw/aes_ctrl_pkg.sv ====
// State encodings for the round controller and the key expansion sequencer
package aes_ctrl_pkg;

    // Round controller
    typedef enum logic [3:0] {
        ENC_IDLE,
        ENC_ADD_KEY,
        ENC_SUB_SHIFT,
        ENC_SUB_WAIT,
        ENC_MIX,
        ENC_STORE,
        ENC_DONE
    } enc_state_t;

    // Key expansion sequencer
    typedef enum logic [2:0] {
        KEY_IDLE,
        KEY_COPY,
        KEY_SUB,
        KEY_SUB_WAIT,
        KEY_WRITE,
        KEY_READY
    } key_state_t;

endpackage

// ==== hw/aes_key_schedule.sv ====
// AES-256 key expansion into a 15-entry round key register file
`timescale 1ns/1ps

module aes_key_schedule (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_key_t   key,
    input  logic                key_load,
    input  aes_pkg::aes_round_t rk_addr,
    output aes_pkg::aes_block_t round_key,
    output logic                key_ready
);
    import aes_pkg::*;
    import aes_ctrl_pkg::*;

    localparam logic [5:0] LAST_WORD = 6'd59;

    key_state_t key_state;
    logic [5:0] word_idx;
    logic [1:0] sub_cnt;
    logic       sub_valid;
    aes_byte_t  rcon;
    aes_byte_t  sbox_addr;
    aes_byte_t  sbox_data;
    aes_word_t  sub_in;
    aes_word_t  sub_word;
    aes_word_t  temp_word;
    aes_word_t  new_word;

    // Sliding window, win[0] is w[i-8] and win[7] is w[i-1]
    aes_word_t  win [8];
    aes_block_t rk_file [NUM_ROUND_KEYS];

    // RotWord only on every eighth word
    assign sub_in = (word_idx[2] == 1'b0) ? {win[7][23:0], win[7][31:24]} : win[7];

    // Byte 0 of the word sits in the top bits
    assign sbox_addr = sub_in[{~sub_cnt, 3'b000} +: 8];

    always_comb
    begin
        if (word_idx[2:0] == 3'd0)
            temp_word = sub_word ^ {rcon, 24'h000000};
        else if (word_idx[1:0] == 2'd0)
            temp_word = sub_word;
        else
            temp_word = win[7];
    end

    assign new_word = win[0] ^ temp_word;

    aes_sbox u_sbox (
        .clk    (clk),
        .resetn (resetn),
        .addr   (sbox_addr),
        .data   (sbox_data)
    );

    // Sequencer
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            key_state <= KEY_IDLE;
            word_idx <= '0;
            sub_cnt <= '0;
            sub_valid <= 1'b0;
            rcon <= 8'h01;
        end
        else
        begin
            sub_valid <= (key_state == KEY_SUB);
            if (key_load)
            begin
                // Restart from any state
                key_state <= KEY_COPY;
                word_idx <= 6'd8;
                sub_cnt <= '0;
                rcon <= 8'h01;
            end
            else
            begin
                case (key_state)
                    KEY_COPY:
                        key_state <= KEY_SUB;
                    KEY_SUB:
                    begin
                        sub_cnt <= sub_cnt + 2'd1;
                        if (sub_cnt == 2'd3)
                            key_state <= KEY_SUB_WAIT;
                    end
                    // Last S-box byte still in flight
                    KEY_SUB_WAIT:
                        key_state <= KEY_WRITE;
                    KEY_WRITE:
                    begin
                        if (word_idx[2:0] == 3'd0)
                            rcon <= {rcon[6:0], 1'b0};
                        if (word_idx == LAST_WORD)
                            key_state <= KEY_READY;
                        else
                        begin
                            word_idx <= word_idx + 6'd1;
                            // Next word is a multiple of four
                            if (word_idx[1:0] == 2'd3)
                                key_state <= KEY_SUB;
                        end
                    end
                    // Idle and ready hold until key_load
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // Window, SubWord collection and round key file
    always_ff @(posedge clk)
    begin
        if (key_load)
        begin
            for (int j = 0; j < 8; j++)
                win[j] <= key[(7 - j) * 32 +: 32];
        end
        else if (key_state == KEY_COPY)
        begin
            rk_file[0] <= {win[0], win[1], win[2], win[3]};
            rk_file[1] <= {win[4], win[5], win[6], win[7]};
        end
        else if (key_state == KEY_WRITE)
        begin
            for (int j = 0; j < 7; j++)
                win[j] <= win[j + 1];
            win[7] <= new_word;
            // Group of four complete
            if (word_idx[1:0] == 2'd3)
                rk_file[word_idx[5:2]] <= {win[5], win[6], win[7], new_word};
        end

        if (sub_valid)
            sub_word <= {sub_word[23:0], sbox_data};
    end

    assign round_key = rk_file[rk_addr];
    assign key_ready = (key_state == KEY_READY);

endmodule

// ==== hw/aes_mix_columns.sv ====
// MixColumns over all four columns with a registered result
`timescale 1ns/1ps

module aes_mix_columns (
    input  logic                clk,
    input  logic                resetn,
    input  logic                load,
    input  aes_pkg::aes_block_t mix_in,
    output aes_pkg::aes_block_t mix_out
);
    import aes_pkg::*;

    aes_block_t mixed;

    // Multiply by 02 in GF(2^8)
    function automatic aes_byte_t xtime(input aes_byte_t b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Fixed 02 03 01 01 circulant, row 0 in the top byte
    function automatic aes_word_t mix_column(input aes_word_t col);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        mix_column = {
            xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
        };
    endfunction

    // Column 0 in the top word
    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mixed[(3 - c) * 32 +: 32] = mix_column(mix_in[(3 - c) * 32 +: 32]);
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            mix_out <= '0;
        else if (load)
            mix_out <= mixed;
    end

endmodule

// ==== hw/aes_pkg.sv ====
// AES-256 data types and cipher constants shared by datapath and testbench
package aes_pkg;

    // One state or key byte
    typedef logic [7:0] aes_byte_t;

    // Key schedule word
    typedef logic [31:0] aes_word_t;

    // 128-bit block, state byte 0 in bits 127:120, column-major
    typedef logic [127:0] aes_block_t;

    // Full cipher key
    typedef logic [255:0] aes_key_t;

    // Round index 0 to 14
    typedef logic [3:0] aes_round_t;

    // AES-256 round counts
    localparam int NUM_ROUNDS = 14;
    localparam int NUM_ROUND_KEYS = 15;

endpackage

// ==== hw/aes_sbox.sv ====
// Forward AES S-box lookup with one cycle of output latency
`timescale 1ns/1ps

module aes_sbox (
    input  logic               clk,
    input  logic               resetn,
    input  aes_pkg::aes_byte_t addr,
    output aes_pkg::aes_byte_t data
);
    import aes_pkg::*;

    // FIPS-197 forward table, row-major by high nibble
    localparam aes_byte_t SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Registered lookup, looks like a synchronous ROM
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            data <= '0;
        else
            data <= SBOX[addr];
    end

endmodule

// ==== hw/aes_sub_shift.sv ====
// Byte-serial SubBytes with ShiftRows applied on write into a state buffer
`timescale 1ns/1ps

module aes_sub_shift (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  aes_pkg::aes_block_t state_in,
    output aes_pkg::aes_block_t state_out,
    output logic                done
);
    import aes_pkg::*;

    // Bit 4 set means idle, low nibble picks the byte
    logic [4:0] byte_cnt;
    logic       feed;
    logic       wr_en;
    logic [3:0] wr_idx;
    logic [3:0] wr_dest;
    aes_byte_t  sbox_addr;
    aes_byte_t  sbox_data;
    aes_byte_t  state_buf [16];

    // Byte 0 goes out in the start cycle itself
    assign feed = start || !byte_cnt[4];
    assign sbox_addr = state_in[{~byte_cnt[3:0], 3'b000} +: 8];

    aes_sbox u_sbox (
        .clk    (clk),
        .resetn (resetn),
        .addr   (sbox_addr),
        .data   (sbox_data)
    );

    // Row r shifts left by r columns
    assign wr_dest = {wr_idx[3:2] - wr_idx[1:0], wr_idx[1:0]};

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            byte_cnt <= 5'd16;
            wr_en <= 1'b0;
            wr_idx <= '0;
            done <= 1'b0;
        end
        else
        begin
            if (start)
                byte_cnt <= 5'd1;
            else if (!byte_cnt[4])
                byte_cnt <= byte_cnt + 5'd1;
            // Write side trails the feed by the S-box latency
            wr_en <= feed;
            wr_idx <= byte_cnt[3:0];
            done <= wr_en && (wr_idx == 4'hf);
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            state_buf[wr_dest] <= sbox_data;
    end

    always_comb
    begin
        for (int b = 0; b < 16; b++)
            state_out[(15 - b) * 8 +: 8] = state_buf[b];
    end

endmodule

// ==== list.f ====
hw/aes_pkg.sv
hw/aes_ctrl_pkg.sv
hw/aes_sbox.sv
hw/aes_key_schedule.sv
hw/aes_sub_shift.sv
hw/aes_mix_columns.sv
hw/aes256_enc.sv
tb/tb_clock_gen.sv
tb/aes256_enc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AES-256 testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=aes256_enc_tb

verilator --binary --timing --timescale 1ns/1ps --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -f list.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0

// ==== tb/aes256_enc_tb.sv ====
// Testbench for the AES-256 core with known-answer vectors and handshake checks
`timescale 1ns/1ps

module aes256_enc_tb;
    import aes_pkg::*;

    localparam int NUM_VECTORS = 6;
    localparam int KEY_BOUND = 400;
    localparam int BLOCK_BOUND = 600;
    localparam int MAX_GAP = 6;
    localparam int CLK_PERIOD_NS = 4;
    // Each entry may need a key load, a block, an idle gap and some slack
    localparam int WATCHDOG_NS =
        (NUM_VECTORS + 2) * (KEY_BOUND + BLOCK_BOUND + MAX_GAP + 40) * CLK_PERIOD_NS;
    localparam logic [31:0] RAND_SEED = 32'hc2db_b924;

    // FIPS-197 C.3 then SP 800-38A ECB-AES256 blocks 1 to 4 then FIPS-197 again
    localparam aes_key_t VEC_KEY [NUM_VECTORS] = '{
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f,
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4,
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4,
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4,
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4,
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f
    };
    localparam aes_block_t VEC_PLAIN [NUM_VECTORS] = '{
        128'h00112233445566778899aabbccddeeff,
        128'h6bc1bee22e409f96e93d7e117393172a,
        128'hae2d8a571e03ac9c9eb76fac45af8e51,
        128'h30c81c46a35ce411e5fbc1191a0a52ef,
        128'hf69f2445df4f9b17ad2b417be66c3710,
        128'h00112233445566778899aabbccddeeff
    };
    localparam aes_block_t VEC_CIPHER [NUM_VECTORS] = '{
        128'h8ea2b7ca516745bfeafc49904b496089,
        128'hf3eed1bdb5d2a03c064b5a7e3db181f8,
        128'h591ccb10d410ed26dc5ba74a31362870,
        128'hb6ed21b99ca6f4f9f153e7b1beafed1d,
        128'h23304b7a39f9f3ff067d8d8f9e24ecc7,
        128'h8ea2b7ca516745bfeafc49904b496089
    };

    logic       clk;
    logic       resetn;
    aes_key_t   key;
    logic       key_load;
    aes_block_t in_block;
    logic       in_valid;
    logic       key_ready;
    logic       busy;
    aes_block_t out_block;
    logic       out_valid;
    aes_key_t   current_key;
    logic       key_loaded;
    // Last result the output register must hold
    aes_block_t last_out;

    tb_clock_gen clock_gen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    aes256_enc dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .key       (key),
        .key_load  (key_load),
        .in_block  (in_block),
        .in_valid  (in_valid),
        .key_ready (key_ready),
        .busy      (busy),
        .out_block (out_block),
        .out_valid (out_valid)
    );

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input aes_block_t actual,
                               input aes_block_t expected);
        if (actual !== expected)
        begin
            $display("FAIL time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Polls on falling edges for at most KEY_BOUND cycles
    task automatic wait_key_ready();
        int cycles;
        cycles = 0;
        while (key_ready !== 1'b1)
        begin
            if (cycles == KEY_BOUND)
            begin
                $display("Timeout: key_ready did not rise within %0d cycles", KEY_BOUND);
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic load_key(input aes_key_t new_key);
        key = new_key;
        key_load = 1'b1;
        @(negedge clk);
        key_load = 1'b0;
        // Expansion restarted so the key is not usable
        check_value("key_ready", aes_block_t'(key_ready), aes_block_t'(1'b0));
        // Block offered during expansion is dropped
        in_block = ~VEC_PLAIN[0];
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        check_value("busy", aes_block_t'(busy), aes_block_t'(1'b0));
        wait_key_ready();
        check_value("busy", aes_block_t'(busy), aes_block_t'(1'b0));
        check_value("out_valid", aes_block_t'(out_valid), aes_block_t'(1'b0));
        check_value("out_block", out_block, last_out);
        current_key = new_key;
        key_loaded = 1'b1;
    endtask

    task automatic run_block(input int idx, input logic strobe_while_busy);
        int          cycles;
        int unsigned gap;
        in_block = VEC_PLAIN[idx];
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        cycles = 1;
        while (out_valid !== 1'b1)
        begin
            if (cycles == BLOCK_BOUND)
            begin
                $display("Timeout: no out_valid within %0d cycles of block %0d",
                         BLOCK_BOUND, idx);
                stop_with_failure();
            end
            check_value("busy", aes_block_t'(busy), aes_block_t'(1'b1));
            // Previous result stays until the new one is out
            check_value("out_block", out_block, last_out);
            // Second block mid-run must not start or disturb the first
            if (strobe_while_busy && cycles == 8)
            begin
                in_block = ~VEC_PLAIN[idx];
                in_valid = 1'b1;
            end
            else
                in_valid = 1'b0;
            @(negedge clk);
            cycles++;
        end
        in_valid = 1'b0;
        check_value("out_block", out_block, VEC_CIPHER[idx]);
        last_out = VEC_CIPHER[idx];
        // Pulse lasts one cycle and busy is already low
        @(negedge clk);
        check_value("out_valid", aes_block_t'(out_valid), aes_block_t'(1'b0));
        check_value("busy", aes_block_t'(busy), aes_block_t'(1'b0));
        check_value("out_block", out_block, last_out);
        // Result keeps its value through a random idle gap
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap)
        begin
            @(negedge clk);
            check_value("out_valid", aes_block_t'(out_valid), aes_block_t'(1'b0));
            check_value("out_block", out_block, last_out);
        end
    endtask

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: watchdog expired after %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    initial
    begin
        key = '0;
        key_load = 1'b0;
        in_block = '0;
        in_valid = 1'b0;
        current_key = '0;
        key_loaded = 1'b0;
        last_out = '0;
        void'($urandom(RAND_SEED));
        wait (resetn === 1'b1);
        @(negedge clk);
        check_value("key_ready", aes_block_t'(key_ready), aes_block_t'(1'b0));
        check_value("busy", aes_block_t'(busy), aes_block_t'(1'b0));
        check_value("out_valid", aes_block_t'(out_valid), aes_block_t'(1'b0));
        check_value("out_block", out_block, '0);
        // Block must be ignored before any key is loaded
        in_block = VEC_PLAIN[0];
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            check_value("out_valid", aes_block_t'(out_valid), aes_block_t'(1'b0));
            check_value("busy", aes_block_t'(busy), aes_block_t'(1'b0));
            check_value("out_block", out_block, last_out);
        end
        // Key only reloaded when the table entry changes it
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            if (!key_loaded || VEC_KEY[i] !== current_key)
                load_key(VEC_KEY[i]);
            run_block(i, (i == 0) || (i == 3));
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock of 4 ns period with an active-low reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);
    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES = 2;

    // Free-running clock
    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release away from the rising edge
    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule
